// File: verilog/phase_consts.svh
`ifndef PHASE_CONSTS_SVH
`define PHASE_CONSTS_SVH

// ------------------------------
// clock ratio
// ------------------------------

// sampling cycles per data period
`define PH_RATIO        12

// phase counter width, must hold PH_RATIO-1
`define PH_RBITS        4

// upper end of the wrapped delta range
`define PH_HALF         (`PH_RATIO / 2)

// ------------------------------
// lock detection
// ------------------------------

// consecutive in-window edges for a lock
`define PH_LOCK_COUNT   3

// run counter width, must hold PH_LOCK_COUNT
`define PH_CBITS        2

// largest |delta| still treated as in window
`define PH_LOCK_WINDOW  1

`endif

// File: verilog/phase_pkg.sv
`include "phase_consts.svh"

package phase_pkg;

   // ------------------------------
   // scalar types
   // ------------------------------
   typedef logic        [`PH_RBITS-1:0] phase_t;   // cycles since ref edge
   typedef logic signed [`PH_RBITS:0]   delta_t;   // wrapped phase error

   // ------------------------------
   // block outputs
   // ------------------------------

   // one-cycle strobes from the synchronisers
   typedef struct packed {
      logic ref_stb;        // reference toggled
      logic sig_stb;        // input signal toggled
   } sync_stb_t;

   // latched measurement
   typedef struct packed {
      logic   meas_stb;     // new phase/delta this cycle
      phase_t phase;
      delta_t delta;
   } phase_meas_t;

   // lock tracker status, valid the cycle after meas_stb
   typedef struct packed {
      logic in_window;      // last delta inside window
      logic run_full;       // enough in-window edges in a row
   } lock_info_t;

endpackage

// File: verilog/edge_sync.sv
`timescale 1ns/1ps

module edge_sync (
   input  logic                  clk_x_i,     // sampling clock
   input  logic                  rst_n_i,
   input  logic                  clk_e_i,     // data-rate clock
   input  logic                  sig_e_i,     // raw serial input
   output phase_pkg::sync_stb_t  stb_o,
   output logic                  ref_edge_o   // unregistered, leads ref_stb by one
);

   logic ref_e;                   // toggles once per data period
   logic ref_s, ref_x, ref_d;     // sync stages plus history
   logic sig_s, sig_x, sig_d;
   logic sig_edge;

   // ------------------------------
   // reference level, clk_e domain
   // ------------------------------
   always_ff @(posedge clk_e_i) begin
      if (!rst_n_i)
         ref_e <= 1'b0;           // reset seen on clk_e edges
      else
         ref_e <= ~ref_e;
   end

   // ------------------------------
   // synchronisers into clk_x
   // ------------------------------
   always_ff @(posedge clk_x_i) begin
      if (!rst_n_i) begin
         {ref_d, ref_x, ref_s} <= 3'b000;
         {sig_d, sig_x, sig_s} <= 3'b000;
      end else begin
         {ref_d, ref_x, ref_s} <= {ref_x, ref_s, ref_e};
         {sig_d, sig_x, sig_s} <= {sig_x, sig_s, sig_e_i};
      end
   end

   // edge detect on the second stage only
   assign ref_edge_o = ref_x ^ ref_d;
   assign sig_edge   = sig_x ^ sig_d;

   // registered strobes, both paths equally deep
   always_ff @(posedge clk_x_i) begin
      if (!rst_n_i) begin
         stb_o <= '0;
      end else begin
         stb_o.ref_stb <= ref_edge_o;
         stb_o.sig_stb <= sig_edge;
      end
   end

endmodule

// File: verilog/phase_counter.sv
`timescale 1ns/1ps
`include "phase_consts.svh"

module phase_counter (
   input  logic                    clk_x_i,
   input  logic                    rst_n_i,
   input  logic                    ref_edge_i,  // restart count
   input  logic                    sig_stb_i,   // input edge seen
   input  logic                    meas_en_i,   // from control
   output phase_pkg::phase_meas_t  meas_o
);

   import phase_pkg::*;

   localparam phase_t CNT_LAST = phase_t'(`PH_RATIO - 1);
   localparam delta_t HALF_POS = delta_t'(`PH_HALF);
   localparam delta_t HALF_NEG = -HALF_POS;
   localparam delta_t RATIO_D  = delta_t'(`PH_RATIO);

   phase_t cnt_q;     // cycles since last ref edge
   delta_t delta_w;   // error against the stored phase
   logic   take;

   // difference folded into (-HALF, +HALF]
   function automatic delta_t wrap_delta(phase_t now_ph, phase_t old_ph);
      delta_t raw;
      raw = delta_t'({1'b0, now_ph}) - delta_t'({1'b0, old_ph});
      if (raw > HALF_POS)
         return raw - RATIO_D;
      else if (raw <= HALF_NEG)
         return raw + RATIO_D;
      else
         return raw;
   endfunction

   // ------------------------------
   // modulo-RATIO cycle counter
   // ------------------------------
   always_ff @(posedge clk_x_i) begin
      if (!rst_n_i)
         cnt_q <= '0;
      else if (ref_edge_i)
         cnt_q <= '0;             // lands on 0 with ref_stb
      else if (cnt_q == CNT_LAST)
         cnt_q <= '0;
      else
         cnt_q <= cnt_q + phase_t'(1);
   end

   assign take    = sig_stb_i & meas_en_i;
   assign delta_w = wrap_delta(cnt_q, meas_o.phase);

   // ------------------------------
   // phase and delta latch
   // ------------------------------
   always_ff @(posedge clk_x_i) begin
      if (!rst_n_i) begin
         meas_o <= '0;
      end else begin
         meas_o.meas_stb <= take;  // single-cycle pulse
         if (take) begin
            meas_o.phase <= cnt_q;
            meas_o.delta <= delta_w;
         end
      end
   end

endmodule

// File: verilog/lock_tracker.sv
`timescale 1ns/1ps
`include "phase_consts.svh"

module lock_tracker (
   input  logic                    clk_x_i,
   input  logic                    rst_n_i,
   input  phase_pkg::phase_meas_t  meas_i,
   input  logic                    clear_i,   // restart the run
   output phase_pkg::lock_info_t   info_o
);

   import phase_pkg::*;

   typedef logic [`PH_CBITS-1:0] run_t;

   localparam delta_t WINDOW  = delta_t'(`PH_LOCK_WINDOW);
   localparam run_t   RUN_MAX = run_t'(`PH_LOCK_COUNT);

   delta_t mag;       // |delta|
   logic   in_win;
   run_t   run_q;     // consecutive in-window edges
   run_t   run_d;

   // ------------------------------
   // window compare
   // ------------------------------

   // delta never reaches the most negative code, negation is safe
   always_comb begin
      if (meas_i.delta < 0)
         mag = -meas_i.delta;
      else
         mag = meas_i.delta;
   end

   assign in_win = (mag <= WINDOW);

   // saturating run, any miss starts over
   always_comb begin
      if (!in_win)
         run_d = '0;
      else if (run_q == RUN_MAX)
         run_d = run_q;             // hold at full
      else
         run_d = run_q + run_t'(1);
   end

   // ------------------------------
   // status register
   // ------------------------------
   always_ff @(posedge clk_x_i) begin
      if (!rst_n_i) begin
         run_q  <= '0;
         info_o <= '0;
      end else if (clear_i) begin
         run_q  <= '0;
         info_o <= '0;
      end else if (meas_i.meas_stb) begin
         run_q            <= run_d;
         info_o.in_window <= in_win;
         info_o.run_full  <= (run_d == RUN_MAX);
      end
   end

endmodule

// File: verilog/phase_ctrl.sv
`timescale 1ns/1ps
`include "phase_consts.svh"

module phase_ctrl (
   input  logic                   clk_x_i,
   input  logic                   rst_n_i,
   input  logic                   align_i,     // core enable
   input  logic                   cycle_i,     // free-running start when idle
   input  logic                   retry_i,     // leave LOST
   input  logic                   ref_stb_i,
   input  logic                   meas_stb_i,
   input  phase_pkg::lock_info_t  info_i,
   output logic                   meas_en_o,
   output logic                   clear_o,     // tracker clear
   output logic                   start_o,
   output logic                   valid_o,     // locked
   output logic                   error_o      // lock lost
);

   import phase_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ACQUIRE,
      ST_LOCKED,
      ST_LOST
   } state_t;

   localparam phase_t CYC_LAST = phase_t'(`PH_RATIO - 1);

   state_t state_q, state_d;
   logic   info_stb_q;    // tracker status is fresh
   phase_t cyc_cnt_q;     // free-running period counter
   logic   cyc_stb_q;

   // tracker answers one cycle after the measurement
   always_ff @(posedge clk_x_i) begin
      if (!rst_n_i)
         info_stb_q <= 1'b0;
      else
         info_stb_q <= meas_stb_i;
   end

   // ------------------------------
   // lock FSM
   // ------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:    if (align_i) state_d = ST_ACQUIRE;
         ST_ACQUIRE: if (info_stb_q && info_i.run_full) state_d = ST_LOCKED;
         ST_LOCKED:  if (info_stb_q && !info_i.in_window) state_d = ST_LOST;
         ST_LOST:    if (retry_i) state_d = ST_ACQUIRE;
         default:    state_d = ST_IDLE;
      endcase
      if (!align_i)
         state_d = ST_IDLE;          // disable wins from any state
   end

   always_ff @(posedge clk_x_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
         valid_o <= 1'b0;
         error_o <= 1'b0;
      end else begin
         state_q <= state_d;
         valid_o <= (state_d == ST_LOCKED);
         error_o <= (state_d == ST_LOST);    // held until retry
      end
   end

   assign meas_en_o = align_i & (state_q != ST_IDLE);
   assign clear_o   = (state_q == ST_IDLE) | ((state_q == ST_LOST) & retry_i);

   // ------------------------------
   // start strobe
   // ------------------------------
   always_ff @(posedge clk_x_i) begin
      if (!rst_n_i) begin
         cyc_cnt_q <= '0;
         cyc_stb_q <= 1'b0;
      end else begin
         cyc_stb_q <= (cyc_cnt_q == CYC_LAST);
         if (cyc_cnt_q == CYC_LAST)
            cyc_cnt_q <= '0;
         else
            cyc_cnt_q <= cyc_cnt_q + phase_t'(1);
      end
   end

   // aligned: follow the reference, else optional free-run
   always_comb begin
      if (align_i)
         start_o = ref_stb_i;
      else
         start_o = cycle_i & cyc_stb_q;
   end

endmodule

// File: verilog/signal_phase_top.sv
`timescale 1ns/1ps

module signal_phase_top (
   input  logic               clk_x_i,   // sampling clock, RATIO x data rate
   input  logic               rst_n_i,
   input  logic               clk_e_i,   // data clock
   input  logic               sig_e_i,   // serial input
   input  logic               align_i,
   input  logic               cycle_i,
   input  logic               retry_i,
   output logic               start_o,
   output phase_pkg::phase_t  phase_o,
   output phase_pkg::delta_t  delta_o,
   output logic               valid_o,
   output logic               error_o
);

   import phase_pkg::*;

   sync_stb_t   stb;
   logic        ref_edge;
   logic        meas_en;
   logic        clear;
   phase_meas_t meas;
   lock_info_t  info;

   // ------------------------------
   // datapath
   // ------------------------------
   edge_sync u_edge_sync (
      .clk_x_i    (clk_x_i),
      .rst_n_i    (rst_n_i),
      .clk_e_i    (clk_e_i),
      .sig_e_i    (sig_e_i),
      .stb_o      (stb),
      .ref_edge_o (ref_edge)
   );

   phase_counter u_phase_counter (
      .clk_x_i    (clk_x_i),
      .rst_n_i    (rst_n_i),
      .ref_edge_i (ref_edge),
      .sig_stb_i  (stb.sig_stb),
      .meas_en_i  (meas_en),
      .meas_o     (meas)
   );

   lock_tracker u_lock_tracker (
      .clk_x_i (clk_x_i),
      .rst_n_i (rst_n_i),
      .meas_i  (meas),
      .clear_i (clear),
      .info_o  (info)
   );

   // ------------------------------
   // control
   // ------------------------------
   phase_ctrl u_phase_ctrl (
      .clk_x_i    (clk_x_i),
      .rst_n_i    (rst_n_i),
      .align_i    (align_i),
      .cycle_i    (cycle_i),
      .retry_i    (retry_i),
      .ref_stb_i  (stb.ref_stb),
      .meas_stb_i (meas.meas_stb),
      .info_i     (info),
      .meas_en_o  (meas_en),
      .clear_o    (clear),
      .start_o    (start_o),
      .valid_o    (valid_o),
      .error_o    (error_o)
   );

   assign phase_o = meas.phase;   // straight from the latch
   assign delta_o = meas.delta;

endmodule

// File: test/signal_phase_checker.sv
`timescale 1ns/1ps

module signal_phase_checker (
   input logic clk_x_i,
   input logic rst_n_i,
   input logic align_i,
   input logic start_o,
   input logic valid_o,
   input logic error_o
);

   // ------------------------------
   // status outputs
   // ------------------------------

   // locked and lost are exclusive
   a_valid_error_excl: assert property (
      @(posedge clk_x_i) disable iff (!rst_n_i)
      !(valid_o && error_o))
      else $error("valid_o and error_o high in the same cycle");

   // disable drops both flags one cycle later
   a_flags_low_unaligned: assert property (
      @(posedge clk_x_i) disable iff (!rst_n_i)
      !align_i |=> (!valid_o && !error_o))
      else $error("status flag high while align_i is low");

   // ------------------------------
   // start strobe
   // ------------------------------
   a_start_single: assert property (
      @(posedge clk_x_i) disable iff (!rst_n_i)
      start_o |=> !start_o)
      else $error("start_o high for two cycles in a row");

endmodule

// File: test/signal_phase_tb.sv
`timescale 1ns/1ps
`include "phase_consts.svh"

module signal_phase_tb;

   import phase_pkg::*;

   typedef struct packed {
      phase_t     phase;    // last latched phase
      delta_t     delta;
      logic [3:0] run;      // in-window edges in a row
      logic       valid;
      logic       error;
   } model_t;

   logic   clk_x_i, rst_n_i, clk_e_i, sig_e_i;
   logic   align_i, cycle_i, retry_i;
   logic   start_o, valid_o, error_o;
   phase_t phase_o;
   delta_t delta_o;

   int     seed = 53409;
   int     err_phase, err_delta, err_flag, err_start, err_timeout;
   phase_t exp_q[$];        // phases still to be measured
   model_t model;

   signal_phase_top UUT (.*);

   bind signal_phase_top signal_phase_checker u_checker (.*);

   initial begin
      clk_x_i = 1'b0;
      forever #20 clk_x_i = ~clk_x_i;   // 40 ns
   end

   // ------------------------------
   // reference model
   // ------------------------------
   function automatic model_t ref_model(model_t m, phase_t ph);
      int   raw;
      logic in_win;
      raw = int'(ph) - int'(m.phase);
      if (raw > `PH_RATIO / 2)
         raw = raw - `PH_RATIO;           // fold into (-half, +half]
      else if (raw <= -(`PH_RATIO / 2))
         raw = raw + `PH_RATIO;
      m.phase = ph;
      m.delta = delta_t'(raw);
      in_win  = (raw <= `PH_LOCK_WINDOW) && (raw >= -`PH_LOCK_WINDOW);
      if (!in_win)
         m.run = 4'd0;
      else if (m.run != 4'(`PH_LOCK_COUNT))
         m.run = m.run + 4'd1;
      if (m.valid && !in_win) begin
         m.valid = 1'b0;                  // lock lost
         m.error = 1'b1;
      end else if (!m.valid && !m.error && m.run == 4'(`PH_LOCK_COUNT)) begin
         m.valid = 1'b1;
      end
      return m;
   endfunction

   // ------------------------------
   // compare tasks
   // ------------------------------
   task automatic check_phase(input phase_t got, input phase_t exp, input string what);
      if (got !== exp) begin
         err_phase++;
         $display("ERR %0t ns: %s phase_o %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_delta(input delta_t got, input delta_t exp, input string what);
      if (got !== exp) begin
         err_delta++;
         $display("ERR %0t ns: %s delta_o %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input bit got, input bit exp, input string what);
      if (got !== exp) begin
         err_flag++;
         $display("ERR %0t ns: %s is %0b, expected %0b", $time, what, got, exp);
      end
   endtask

   // one data period with clk_e high for the first half
   task automatic drive_period(input int d, input bit toggle, input bit retry);
      for (int i = 0; i < `PH_RATIO; i++) begin
         @(posedge clk_x_i);
         #2;
         clk_e_i = (i < `PH_RATIO / 2);
         if (toggle && i == d) begin
            sig_e_i = ~sig_e_i;
            if (align_i)
               exp_q.push_back(phase_t'(d % `PH_RATIO));
         end
         if (retry && i == 6) begin
            retry_i     = 1'b1;
            model.run   = 4'd0;           // tracker cleared with it
            model.error = 1'b0;
         end else begin
            retry_i = 1'b0;
         end
      end
   endtask

   // keep a fixed offset until a flag rises or the bound runs out
   task automatic drive_until(input int d, input bit want_err, input string what);
      bit seen;
      seen = 1'b0;
      for (int n = 0; n < 8 && !seen; n++) begin
         drive_period(d, 1'b1, 1'b0);
         seen = want_err ? error_o : valid_o;
      end
      if (!seen) begin
         err_timeout++;
         $display("timeout: %s did not rise within 8 data periods", what);
      end
   endtask

   task automatic count_starts(input int cycles, input int exp);
      int n;
      n = 0;
      repeat (cycles) begin
         @(posedge clk_x_i);
         #1;                              // sample before inputs move
         if (start_o)
            n++;
      end
      if (n != exp) begin
         err_start++;
         $display("ERR %0t ns: %0d start pulses, expected %0d", $time, n, exp);
      end
   endtask

   // ------------------------------
   // compare process
   // ------------------------------
   initial begin : compare
      phase_t ph;
      bit     flag_due[2];      // flag check pending, by age
      model_t flag_exp[2];      // expected flags for those checks
      flag_due[0] = 1'b0;
      flag_due[1] = 1'b0;
      forever begin
         @(negedge clk_x_i);
         if (flag_due[1]) begin                 // tracker then FSM
            check_flag(valid_o, flag_exp[1].valid, "valid_o");
            check_flag(error_o, flag_exp[1].error, "error_o");
         end
         flag_due[1] = flag_due[0];
         flag_exp[1] = flag_exp[0];
         flag_due[0] = 1'b0;
         if (rst_n_i && UUT.meas.meas_stb) begin
            if (exp_q.size() == 0) begin
               err_flag++;
               $display("measurement at %0t ns with no input edge behind it", $time);
            end else begin
               ph    = exp_q.pop_front();
               model = ref_model(model, ph);
               check_phase(phase_o, model.phase, "meas");
               check_delta(delta_o, model.delta, "meas");
               flag_due[0] = 1'b1;
               flag_exp[0] = model;
            end
         end
      end
   end

   initial begin : watchdog
      #200000;
      $display("timeout: simulation still running after 200 us");
      $display("Test failures found");
      $finish;
   end

   // ------------------------------
   // stimulus
   // ------------------------------
   initial begin : stimulus
      int d;
      {rst_n_i, clk_e_i, sig_e_i, align_i, cycle_i, retry_i} = 6'b0;
      model = '0;
      fork
         drive_period(0, 1'b0, 1'b0);     // clk_e runs during reset
         begin
            repeat (4) @(posedge clk_x_i);
            #2;
            rst_n_i = 1'b1;
         end
      join
      check_flag(start_o, 1'b0, "reset start_o");
      check_flag(valid_o, 1'b0, "reset valid_o");
      check_flag(error_o, 1'b0, "reset error_o");
      check_phase(phase_o, '0, "reset");
      check_delta(delta_o, '0, "reset");

      align_i = 1'b1;                     // random offsets
      repeat (8) begin
         d = $unsigned($random(seed)) % `PH_RATIO;
         drive_period(d, 1'b1, 1'b0);
      end
      drive_period(0, 1'b0, 1'b0);        // let the last one settle
      align_i = 1'b0;
      model.run   = 4'd0;
      model.valid = 1'b0;
      model.error = 1'b0;
      drive_period(0, 1'b0, 1'b0);

      align_i = 1'b1;                     // fresh acquire at a steady offset
      drive_until(3, 1'b0, "valid_o");
      fork
         drive_period(3, 1'b1, 1'b0);
         count_starts(`PH_RATIO, 1);      // one reference strobe per period
      join
      check_flag(error_o, 1'b0, "locked error_o");

      drive_until(9, 1'b1, "error_o");    // jump out of the window
      drive_period(9, 1'b1, 1'b0);
      check_flag(error_o, 1'b1, "lost error_o");
      check_flag(valid_o, 1'b0, "lost valid_o");
      drive_period(9, 1'b1, 1'b1);        // retry mid period
      drive_until(9, 1'b0, "valid_o after retry");

      drive_period(9, 1'b0, 1'b0);
      align_i = 1'b0;                     // free-running start
      cycle_i = 1'b1;
      model.run   = 4'd0;
      model.valid = 1'b0;
      model.error = 1'b0;
      fork
         repeat (3) drive_period(5, 1'b1, 1'b0);
         count_starts(3 * `PH_RATIO, 3);
      join
      check_phase(phase_o, model.phase, "held");
      check_flag(valid_o, 1'b0, "unaligned valid_o");
      check_flag(error_o, 1'b0, "unaligned error_o");
      cycle_i = 1'b0;
      fork
         repeat (3) drive_period(0, 1'b0, 1'b0);
         count_starts(3 * `PH_RATIO, 0);
      join

      if (exp_q.size() != 0) begin
         err_flag++;
         $display("%0d input edges never produced a measurement", exp_q.size());
      end

      $display("errors: phase %0d delta %0d flag %0d start %0d timeout %0d",
               err_phase, err_delta, err_flag, err_start, err_timeout);
      if (err_phase + err_delta + err_flag + err_start + err_timeout == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+verilog
verilog/phase_pkg.sv
verilog/edge_sync.sv
verilog/phase_counter.sv
verilog/lock_tracker.sv
verilog/phase_ctrl.sv
verilog/signal_phase_top.sv
test/signal_phase_checker.sv
test/signal_phase_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the phase recovery testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
   -f vlog.f \
   --top-module signal_phase_tb \
   -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vsignal_phase_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "Test failures found" "$LOG"; then
   echo "simulation FAILED"
   exit 1
fi

echo "simulation PASSED"
exit 0
